// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rsi_tb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build and run, then decide the result from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: list.f
+incdir+logic
+incdir+testbench
logic/rsi_pkg.sv
logic/price_window.sv
logic/rsi_divider.sv
logic/signal_decision.sv
logic/rsi_top.sv
testbench/rsi_tb.sv

// File: logic/price_window.sv
`include "rsi_macros.svh"

module price_window
    import rsi_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  price_t price,
    input  logic   price_valid,
    input  logic   eod,
    output logic   sums_valid,
    output sum_t   gain_sum,
    output sum_t   total_sum
);

    localparam int PERIOD = `RSI_PERIOD;
    localparam int PTR_W  = $clog2(PERIOD);
    localparam int CNT_W  = $clog2(PERIOD + 1);

    // Circular window of gains and losses
    sum_t gain_buf [PERIOD];
    sum_t loss_buf [PERIOD];

    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] fill_cnt;
    logic [CNT_W-1:0] fill_next;

    price_t prev_price;
    logic   prev_set;

    sum_t gain_acc;
    sum_t loss_acc;
    sum_t new_gain;
    sum_t new_loss;
    sum_t old_gain;
    sum_t old_loss;

    logic take;
    logic push;
    logic window_full;

    // A sample arriving with eod is dropped
    assign take = price_valid && !eod;
    assign push = take && prev_set;
    assign window_full = (fill_cnt == CNT_W'(PERIOD));

    always_comb begin
        if (price > prev_price) begin
            new_gain = sum_t'(price - prev_price);
            new_loss = '0;
        end else begin
            new_gain = '0;
            new_loss = sum_t'(prev_price - price);
        end
        // Entry under the write pointer only counts once the window has wrapped
        old_gain  = window_full ? gain_buf[wr_ptr] : '0;
        old_loss  = window_full ? loss_buf[wr_ptr] : '0;
        fill_next = window_full ? fill_cnt : fill_cnt + CNT_W'(1);
    end

    always_ff @(posedge clk) begin
        if (take) begin
            prev_price <= price;
        end
        if (push) begin
            gain_buf[wr_ptr] <= new_gain;
            loss_buf[wr_ptr] <= new_loss;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_set   <= 1'b0;
            wr_ptr     <= '0;
            fill_cnt   <= '0;
            gain_acc   <= '0;
            loss_acc   <= '0;
            sums_valid <= 1'b0;
        end else if (eod) begin
            // End of day restarts the warm-up
            prev_set   <= 1'b0;
            wr_ptr     <= '0;
            fill_cnt   <= '0;
            gain_acc   <= '0;
            loss_acc   <= '0;
            sums_valid <= 1'b0;
        end else begin
            sums_valid <= 1'b0;
            if (take) begin
                prev_set <= 1'b1;
            end
            if (push) begin
                gain_acc   <= gain_acc - old_gain + new_gain;
                loss_acc   <= loss_acc - old_loss + new_loss;
                wr_ptr     <= (wr_ptr == PTR_W'(PERIOD - 1)) ? '0 : wr_ptr + PTR_W'(1);
                fill_cnt   <= fill_next;
                sums_valid <= (fill_next == CNT_W'(PERIOD));
            end
        end
    end

    assign gain_sum  = gain_acc;
    assign total_sum = gain_acc + loss_acc;

    // The divider relies on a quotient of at most 100
    a_gain_within_total: assert property (
        @(posedge clk) disable iff (reset)
        sums_valid |-> (gain_sum <= total_sum)
    );

endmodule

// File: logic/rsi_divider.sv
`include "rsi_macros.svh"

module rsi_divider
    import rsi_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic sums_valid,
    input  sum_t gain_sum,
    input  sum_t total_sum,
    output logic quot_valid,
    output rsi_t quotient
);

    localparam int STAGES = `RSI_DIV_STAGES;
    localparam int SUM_W  = $bits(sum_t);
    localparam int DVD_W  = $bits(dividend_t);
    localparam rsi_t NEUTRAL_RSI = rsi_t'(50);

    // Rank 0 is the input register, ranks 1 to STAGES resolve one bit each
    logic [STAGES:0] vld;
    logic zero_q [0:STAGES];
    sum_t rem_q  [0:STAGES];
    sum_t dvs_q  [0:STAGES];
    // Holds the unused dividend bits on top and the quotient bits below
    rsi_t quo_q  [0:STAGES];

    logic [SUM_W:0] trial [1:STAGES];
    logic           fits  [1:STAGES];

    dividend_t dividend;
    logic      total_zero;

    assign dividend   = dividend_t'(gain_sum) * dividend_t'(100);
    assign total_zero = (total_sum == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld <= {vld[STAGES-1:0], sums_valid};
        end
    end

    // Shift the next dividend bit into the remainder and try the divisor
    always_comb begin
        for (int k = 1; k <= STAGES; k++) begin
            trial[k] = {rem_q[k-1], quo_q[k-1][STAGES-1]};
            fits[k]  = (trial[k] >= {1'b0, dvs_q[k-1]});
        end
    end

    always_ff @(posedge clk) begin
        zero_q[0] <= total_zero;
        dvs_q[0]  <= total_sum;
        if (total_zero) begin
            // No movement at all reads as neutral
            rem_q[0] <= '0;
            quo_q[0] <= NEUTRAL_RSI;
        end else begin
            rem_q[0] <= dividend[DVD_W-1 -: SUM_W];
            quo_q[0] <= dividend[STAGES-1:0];
        end

        for (int k = 1; k <= STAGES; k++) begin
            zero_q[k] <= zero_q[k-1];
            dvs_q[k]  <= dvs_q[k-1];
            if (zero_q[k-1]) begin
                rem_q[k] <= rem_q[k-1];
                quo_q[k] <= quo_q[k-1];
            end else if (fits[k]) begin
                rem_q[k] <= SUM_W'(trial[k] - {1'b0, dvs_q[k-1]});
                quo_q[k] <= {quo_q[k-1][STAGES-2:0], 1'b1};
            end else begin
                rem_q[k] <= trial[k][SUM_W-1:0];
                quo_q[k] <= {quo_q[k-1][STAGES-2:0], 1'b0};
            end
        end
    end

    assign quot_valid = vld[STAGES];
    assign quotient   = quo_q[STAGES];

    // Holds only while the upstream gain never exceeds the total
    for (genvar k = 1; k <= STAGES; k++) begin : g_rem_check
        a_rem_below_divisor: assert property (
            @(posedge clk) disable iff (reset)
            (vld[k] && !zero_q[k]) |-> (rem_q[k] < dvs_q[k])
        );
    end

endmodule

// File: logic/rsi_macros.svh
`ifndef RSI_MACROS_SVH
`define RSI_MACROS_SVH

// Width of one price sample
`define RSI_PRICE_W 16

// Number of price differences kept in the window
`define RSI_PERIOD 14

// Width of a window sum, large enough for 14 full-scale differences
`define RSI_SUM_W 20

// Width of an rsi value, 0 to 100
`define RSI_OUT_W 7

// One divider stage per quotient bit
`define RSI_DIV_STAGES 7

// Trading thresholds
`define RSI_BUY_LEVEL 30
`define RSI_SELL_LEVEL 70

`endif

// File: logic/rsi_pkg.sv
`include "rsi_macros.svh"

package rsi_pkg;

    // One price sample from the feed
    typedef logic [`RSI_PRICE_W-1:0] price_t;

    // Running gain or loss sum, also used for a single buffered entry
    typedef logic [`RSI_SUM_W-1:0] sum_t;

    // Relative strength index, 0 to 100
    typedef logic [`RSI_OUT_W-1:0] rsi_t;

    // Gain sum scaled by 100 ahead of the division
    // Top bits line up with the sum width, low bits with the quotient
    typedef logic [`RSI_SUM_W+`RSI_DIV_STAGES-1:0] dividend_t;

endpackage

// File: logic/rsi_top.sv
`include "rsi_macros.svh"

module rsi_top
    import rsi_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  price_t price,
    input  logic   price_valid,
    input  logic   eod,
    output logic   rsi_valid,
    output rsi_t   rsi,
    output logic   buy,
    output logic   sell
);

    // Window to divider
    logic sums_valid;
    sum_t gain_sum;
    sum_t total_sum;

    // Divider to decision stage
    logic quot_valid;
    rsi_t quotient;

    price_window price_window_i (
        .clk         (clk),
        .reset       (reset),
        .price       (price),
        .price_valid (price_valid),
        .eod         (eod),
        .sums_valid  (sums_valid),
        .gain_sum    (gain_sum),
        .total_sum   (total_sum)
    );

    rsi_divider rsi_divider_i (
        .clk        (clk),
        .reset      (reset),
        .sums_valid (sums_valid),
        .gain_sum   (gain_sum),
        .total_sum  (total_sum),
        .quot_valid (quot_valid),
        .quotient   (quotient)
    );

    signal_decision signal_decision_i (
        .clk        (clk),
        .reset      (reset),
        .quot_valid (quot_valid),
        .quotient   (quotient),
        .rsi_valid  (rsi_valid),
        .rsi        (rsi),
        .buy        (buy),
        .sell       (sell)
    );

endmodule

// File: logic/signal_decision.sv
`include "rsi_macros.svh"

module signal_decision
    import rsi_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic quot_valid,
    input  rsi_t quotient,
    output logic rsi_valid,
    output rsi_t rsi,
    output logic buy,
    output logic sell
);

    localparam rsi_t BUY_LEVEL  = rsi_t'(`RSI_BUY_LEVEL);
    localparam rsi_t SELL_LEVEL = rsi_t'(`RSI_SELL_LEVEL);
    localparam rsi_t RSI_MAX    = rsi_t'(100);

    always_ff @(posedge clk) begin
        if (quot_valid) begin
            rsi <= quotient;
        end
    end

    // Flags are qualified so they pulse together with rsi_valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsi_valid <= 1'b0;
            buy       <= 1'b0;
            sell      <= 1'b0;
        end else begin
            rsi_valid <= quot_valid;
            buy       <= quot_valid && (quotient < BUY_LEVEL);
            sell      <= quot_valid && (quotient > SELL_LEVEL);
        end
    end

    a_buy_sell_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(buy && sell)
    );

    // Range depends on the sums and the divider upstream
    a_rsi_in_range: assert property (
        @(posedge clk) disable iff (reset)
        rsi_valid |-> (rsi <= RSI_MAX)
    );

endmodule

// File: testbench/rsi_model.svh
`ifndef RSI_MODEL_SVH
`define RSI_MODEL_SVH

// Xorshift32 random source
logic [31:0] rng_state = 32'h5ba4_b61c;

function automatic logic [31:0] next_random();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
endfunction

// Price history as seen by the reference
int model_prev;
bit model_prev_set;
int gain_hist[$];
int loss_hist[$];

// Expected results in issue order, with the cycle each one is due
int exp_rsi_q[$];
bit exp_buy_q[$];
bit exp_sell_q[$];
int exp_due_q[$];

// End of day forgets the history but not the results already issued
function automatic void clear_history();
    model_prev_set = 1'b0;
    gain_hist.delete();
    loss_hist.delete();
endfunction

function automatic int rsi_of(input int gains, input int losses);
    int r;
    if (gains + losses == 0) begin
        r = 50;
    end else begin
        r = (100 * gains) / (gains + losses);
    end
    return r;
endfunction

function automatic void push_sample(input int p, input int due);
    int g_sum;
    int l_sum;
    int r;
    g_sum = 0;
    l_sum = 0;
    if (model_prev_set) begin
        if (p > model_prev) begin
            gain_hist.push_back(p - model_prev);
            loss_hist.push_back(0);
        end else begin
            gain_hist.push_back(0);
            loss_hist.push_back(model_prev - p);
        end
        if (gain_hist.size() > `RSI_PERIOD) begin
            void'(gain_hist.pop_front());
            void'(loss_hist.pop_front());
        end
        // Full window, so this sample yields a result
        if (gain_hist.size() == `RSI_PERIOD) begin
            foreach (gain_hist[i]) begin
                g_sum += gain_hist[i];
                l_sum += loss_hist[i];
            end
            r = rsi_of(g_sum, l_sum);
            exp_rsi_q.push_back(r);
            exp_buy_q.push_back(r < `RSI_BUY_LEVEL);
            exp_sell_q.push_back(r > `RSI_SELL_LEVEL);
            exp_due_q.push_back(due);
        end
    end
    model_prev     = p;
    model_prev_set = 1'b1;
endfunction

function automatic void drop_expected();
    void'(exp_rsi_q.pop_front());
    void'(exp_buy_q.pop_front());
    void'(exp_sell_q.pop_front());
    void'(exp_due_q.pop_front());
endfunction

`endif

// File: testbench/rsi_tb.sv
`include "rsi_macros.svh"

module rsi_tb
    import rsi_pkg::*;
();

    logic   clk;
    logic   reset;
    price_t price;
    logic   price_valid;
    logic   eod;
    logic   rsi_valid;
    rsi_t   rsi;
    logic   buy;
    logic   sell;

    int cycle_cnt    = 0;
    int error_count  = 0;
    int check_count  = 0;
    int results_seen = 0;
    int tests_run    = 0;
    // Constant rsi the current test expects, -1 when only the model applies
    int fixed_rsi    = -1;

    `include "rsi_model.svh"

    rsi_top rsi_top_i (
        .clk         (clk),
        .reset       (reset),
        .price       (price),
        .price_valid (price_valid),
        .eod         (eod),
        .rsi_valid   (rsi_valid),
        .rsi         (rsi),
        .buy         (buy),
        .sell        (sell)
    );

    always #50 clk = ~clk;

    // Number of rising edges so far
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        assert (expected == actual) else begin
            $display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic abort_run(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic finish_test(input string name, input int err_mark);
        tests_run++;
        $display("test %s done, %0d errors", name, error_count - err_mark);
    endtask

    // Outputs are compared mid-cycle, well away from the edges
    always @(negedge clk) begin
        if (!reset) begin
            while (exp_due_q.size() > 0 && exp_due_q[0] < cycle_cnt) begin
                report_failure("an expected result did not arrive in its cycle");
                drop_expected();
            end
            if (rsi_valid) begin
                results_seen++;
                assert (exp_due_q.size() > 0)
                else report_failure("rsi_valid high with no result due");
                if (exp_due_q.size() > 0) begin
                    check_value("rsi_valid cycle", exp_due_q[0], cycle_cnt);
                    check_value("rsi", exp_rsi_q[0], int'(rsi));
                    check_value("buy", int'(exp_buy_q[0]), int'(buy));
                    check_value("sell", int'(exp_sell_q[0]), int'(sell));
                    drop_expected();
                end
                if (fixed_rsi >= 0) begin
                    check_value("rsi", fixed_rsi, int'(rsi));
                    check_value("buy", (fixed_rsi < `RSI_BUY_LEVEL) ? 1 : 0, int'(buy));
                    check_value("sell", (fixed_rsi > `RSI_SELL_LEVEL) ? 1 : 0, int'(sell));
                end
            end else begin
                assert (!buy && !sell) else report_failure("buy or sell high without rsi_valid");
            end
        end
    end

    // Inputs change 10 units after the edge and are taken at the next one
    task automatic drive(input bit valid, input int p, input bit day_end);
        @(posedge clk);
        #10;
        price_valid = valid;
        price       = price_t'(p);
        eod         = day_end;
        if (day_end) begin
            clear_history();
        end else if (valid) begin
            push_sample(p, cycle_cnt + 10);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive(1'b0, 0, 1'b0);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        drive(1'b0, 0, 1'b0);
        while (exp_due_q.size() > 0 && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (exp_due_q.size() > 0) begin
            abort_run("outstanding results");
        end else begin
            repeat (2) @(negedge clk);
        end
    endtask

    // Random walk with an upward or downward drift, kept in price range
    function automatic int walk_price(input int cur, input bit up);
        int next;
        next = cur + int'(next_random() & 32'h3f) - (up ? 16 : 47);
        if (next < 0) begin
            next = 0;
        end else if (next > 65535) begin
            next = 65535;
        end
        return next;
    endfunction

    initial begin
        int mark;
        int base_seen;
        int quiet_seen;
        int cur;
        int first_due;
        int seen_cycle;
        int waited;
        bit seen;
        bit up;
        logic [31:0] r;

        clk         = 1'b0;
        reset       = 1'b1;
        price       = '0;
        price_valid = 1'b0;
        eod         = 1'b0;
        seen_cycle  = 0;
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b0;

        // Warm-up, first result exactly nine cycles after the 15th sample
        mark = error_count;
        cur  = 20000;
        for (int i = 0; i < 15; i++) begin
            cur = walk_price(cur, 1'b1);
            drive(1'b1, cur, 1'b0);
        end
        first_due = cycle_cnt + 10;
        assert (results_seen == 0) else report_failure("rsi_valid seen during warm-up");
        drive(1'b0, 0, 1'b0);
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < 20) begin
            @(negedge clk);
            waited++;
            if (rsi_valid) begin
                seen       = 1'b1;
                seen_cycle = cycle_cnt;
            end
        end
        if (!seen) begin
            abort_run("the first result after warm-up");
        end else begin
            check_value("first rsi_valid cycle", first_due, seen_cycle);
        end
        wait_drain();
        finish_test("warm_up", mark);

        // Random walk with gaps in price_valid
        mark = error_count;
        up   = 1'b1;
        for (int i = 0; i < 300; i++) begin
            if (i % 60 == 59) begin
                up = !up;
            end
            r = next_random();
            if (r[9:8] != 2'b00) begin
                cur = walk_price(cur, up);
                drive(1'b1, cur, 1'b0);
            end else begin
                drive(1'b0, 0, 1'b0);
            end
        end
        wait_drain();
        finish_test("random_prices", mark);

        // Flat prices
        mark = error_count;
        drive(1'b0, 0, 1'b1);
        base_seen = results_seen;
        fixed_rsi = 50;
        for (int i = 0; i < 20; i++) begin
            drive(1'b1, 31000, 1'b0);
        end
        wait_drain();
        fixed_rsi = -1;
        check_value("flat result count", 6, results_seen - base_seen);
        finish_test("flat_prices", mark);

        // Strictly rising, then strictly falling
        mark = error_count;
        drive(1'b0, 0, 1'b1);
        fixed_rsi = 100;
        cur = 1000;
        for (int i = 0; i < 20; i++) begin
            cur = cur + 1 + int'(next_random() & 32'hf);
            drive(1'b1, cur, 1'b0);
        end
        wait_drain();
        drive(1'b0, 0, 1'b1);
        fixed_rsi = 0;
        cur = 60000;
        for (int i = 0; i < 20; i++) begin
            cur = cur - 1 - int'(next_random() & 32'hf);
            drive(1'b1, cur, 1'b0);
        end
        wait_drain();
        fixed_rsi = -1;
        finish_test("steady_trends", mark);

        // End of day while results are in flight, sample on the eod cycle dropped
        mark      = error_count;
        base_seen = results_seen;
        for (int i = 0; i < 10; i++) begin
            cur = walk_price(cur, 1'b1);
            drive(1'b1, cur, 1'b0);
        end
        drive(1'b1, cur + 100, 1'b1);
        for (int i = 0; i < 14; i++) begin
            cur = walk_price(cur, 1'b0);
            drive(1'b1, cur, 1'b0);
        end
        wait_drain();
        check_value("in-flight result count", 10, results_seen - base_seen);
        quiet_seen = results_seen;
        idle_cycles(12);
        assert (results_seen == quiet_seen)
        else report_failure("result issued before the new window filled");
        cur = walk_price(cur, 1'b0);
        drive(1'b1, cur, 1'b0);
        wait_drain();
        check_value("post-eod result count", 1, results_seen - quiet_seen);
        finish_test("end_of_day", mark);

        // A sample on every cycle
        mark      = error_count;
        base_seen = results_seen;
        up        = 1'b1;
        for (int i = 0; i < 200; i++) begin
            if (i % 40 == 39) begin
                up = !up;
            end
            cur = walk_price(cur, up);
            drive(1'b1, cur, 1'b0);
        end
        // Last result is due nine cycles after its sample edge
        idle_cycles(11);
        check_value("back-to-back result count", 200, results_seen - base_seen);
        assert (exp_due_q.size() == 0) else report_failure("expected results left over");
        finish_test("back_to_back", mark);

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
